// File: source/l2_cache_pkg.sv
`default_nettype none

package l2_cache_pkg;
	localparam int LINE_WORDS = 4;              // 32-bit words per line
	localparam int LINE_BITS = LINE_WORDS * 32;
	localparam int MASK_BITS = LINE_BITS / 8;   // One enable per byte
	localparam int ADDR_BITS = 26;              // Line address, not byte address

	typedef logic [ADDR_BITS-1:0] line_addr_t;
	typedef logic [LINE_BITS-1:0] line_data_t;
	typedef logic [MASK_BITS-1:0] line_mask_t;

	typedef enum logic [0:0] {
		OP_LOAD  = 1'b0,
		OP_STORE = 1'b1
	} l2_op_t;

	typedef struct packed {
		logic [1:0] core;
		logic [1:0] strand;
		l2_op_t     op;
		line_addr_t address;
		line_data_t data;
		line_mask_t mask;       // Don't care on loads
	} l2_req_t;

	typedef struct packed {
		logic [1:0] core;
		logic [1:0] strand;
		l2_op_t     op;         // Reads OP_LOAD on restarted fills
		line_addr_t address;
		line_data_t data;       // Whole line, after any store merge
	} l2_rsp_t;

	typedef struct packed {
		l2_req_t    req;        // Replayed as-is after the fill
		logic       writeback;  // Victim was valid and dirty
		line_addr_t victim_addr;
		line_data_t victim_data;
	} miss_entry_t;
endpackage

`default_nettype wire

// File: source/l2_axi_pkg.sv
`default_nettype none

package l2_axi_pkg;
	localparam int AXI_ADDR_BITS = 32;
	localparam int AXI_DATA_BITS = 32;  // One line word per beat

	// awlen/arlen encoding is beats minus one
	localparam logic [7:0] BURST_LEN = 8'(l2_cache_pkg::LINE_WORDS - 1);

	typedef enum logic [2:0] {
		BUS_IDLE    = 3'd0,   // Waiting for a queued miss
		BUS_WB_ADDR = 3'd1,   // Victim write address
		BUS_WB_DATA = 3'd2,   // Victim data beats
		BUS_WB_RESP = 3'd3,   // Write response
		BUS_RD_ADDR = 3'd4,   // Fill read address
		BUS_RD_DATA = 3'd5,   // Fill data beats into line buffer
		BUS_RESTART = 3'd6    // Offer filled request back to the arbiter
	} bus_state_t;
endpackage

`default_nettype wire

// File: source/l2_request_arb.sv
`default_nettype none

module l2_request_arb (
	input wire                        clk,
	input wire                        rst,
	input wire                        core_valid,
	input wire l2_cache_pkg::l2_req_t core_req,
	output logic                      l2req_ready,
	output logic                      pc_event_l2_wait,
	input wire                        restart_valid,
	input wire l2_cache_pkg::l2_req_t restart_req,
	input wire l2_cache_pkg::line_data_t restart_data,
	input wire                        queue_room,
	output logic                      restart_taken,
	output logic                      arb_valid,
	output l2_cache_pkg::l2_req_t     arb_req,
	output logic                      arb_is_fill,
	output l2_cache_pkg::line_data_t  arb_fill_data
);
	// Restarts always win; a restart never needs a fresh queue slot
	assign l2req_ready = !restart_valid && queue_room;
	assign restart_taken = restart_valid;
	assign pc_event_l2_wait = core_valid && !l2req_ready;   // Held off this cycle

	always_ff @(posedge clk) begin
		if (rst) begin
			arb_valid <= 1'b0;
		end else begin
			arb_valid <= restart_valid || (core_valid && l2req_ready);
		end
	end

	// Payload, qualified by arb_valid
	always_ff @(posedge clk) begin
		arb_is_fill <= restart_valid;
		arb_req <= restart_valid ? restart_req : core_req;
		arb_fill_data <= restart_data;      // Only looked at on fills
	end
endmodule

`default_nettype wire

// File: source/l2_cache_lookup.sv
`default_nettype none

module l2_cache_lookup #(
	parameter int NUM_SETS = 16
) (
	input wire                           clk,
	input wire                           rst,
	input wire                           arb_valid,
	input wire l2_cache_pkg::l2_req_t    arb_req,
	input wire                           arb_is_fill,
	input wire l2_cache_pkg::line_data_t arb_fill_data,
	output logic                         hit_valid,
	output l2_cache_pkg::l2_rsp_t        hit_rsp,
	output logic                         miss_event,
	output logic                         miss_valid,
	output l2_cache_pkg::miss_entry_t    miss_entry
);
	import l2_cache_pkg::*;

	localparam int SET_BITS = $clog2(NUM_SETS);
	localparam int TAG_BITS = ADDR_BITS - SET_BITS;

	logic [NUM_SETS-1:0] valid_bits;
	logic [NUM_SETS-1:0] dirty_bits;
	logic [TAG_BITS-1:0] tag_mem [NUM_SETS];
	line_data_t          data_mem [NUM_SETS];

	logic [SET_BITS-1:0] s1_set;
	logic                s1_fwd;

	logic                s2_valid;
	l2_req_t             s2_req;
	logic                s2_fill;
	line_data_t          s2_fill_data;
	logic                s2_line_valid;
	logic                s2_line_dirty;
	logic [TAG_BITS-1:0] s2_tag;
	line_data_t          s2_data;
	logic [SET_BITS-1:0] s2_set;
	logic [TAG_BITS-1:0] s2_req_tag;

	logic                tag_hit;
	logic                old_dirty;
	logic                is_store;
	logic                do_miss;
	logic                do_hit;
	line_data_t          base_line;
	line_data_t          new_line;
	logic                wr_en;
	logic                wr_dirty;
	logic [TAG_BITS-1:0] wr_tag;
	line_data_t          wr_data;

	// Stage one reads the arrays, bypassing a same-set write from stage two
	assign s1_set = arb_req.address[SET_BITS-1:0];
	assign s1_fwd = wr_en && (s2_set == s1_set);

	always_ff @(posedge clk) begin
		if (rst) begin
			s2_valid <= 1'b0;
		end else begin
			s2_valid <= arb_valid;
		end
	end

	always_ff @(posedge clk) begin
		s2_req <= arb_req;
		s2_fill <= arb_is_fill;
		s2_fill_data <= arb_fill_data;
		s2_line_valid <= s1_fwd ? 1'b1 : valid_bits[s1_set];   // Writes leave it valid
		s2_line_dirty <= s1_fwd ? wr_dirty : dirty_bits[s1_set];
		s2_tag <= s1_fwd ? wr_tag : tag_mem[s1_set];
		s2_data <= s1_fwd ? wr_data : data_mem[s1_set];
	end

	// Stage two compares and decides
	assign s2_set = s2_req.address[SET_BITS-1:0];
	assign s2_req_tag = s2_req.address[ADDR_BITS-1:SET_BITS];
	assign tag_hit = s2_line_valid && (s2_tag == s2_req_tag);
	assign old_dirty = s2_line_valid && s2_line_dirty;
	assign is_store = s2_req.op == OP_STORE;
	// A fill over a line dirtied after its writeback was queued must go round again
	assign do_miss = s2_valid && !tag_hit && (!s2_fill || old_dirty);
	assign do_hit = s2_valid && !do_miss;
	assign base_line = tag_hit ? s2_data : s2_fill_data;   // Stale fill data dropped

	always_comb begin
		new_line = base_line;
		for (int i = 0; i < MASK_BITS; i++) begin
			if (is_store && s2_req.mask[i])
				new_line[i*8 +: 8] = s2_req.data[i*8 +: 8];
		end
	end

	// Miss clears dirty since the victim data now rides in the queue
	assign wr_en = (do_hit && (is_store || !tag_hit)) || (do_miss && old_dirty);
	assign wr_dirty = do_miss ? 1'b0 : (is_store || (tag_hit && s2_line_dirty));
	assign wr_tag = do_miss ? s2_tag : s2_req_tag;
	assign wr_data = do_miss ? s2_data : new_line;

	always_ff @(posedge clk) begin
		if (rst) begin
			valid_bits <= '0;
			dirty_bits <= '0;
		end else if (wr_en) begin
			valid_bits[s2_set] <= 1'b1;
			dirty_bits[s2_set] <= wr_dirty;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[s2_set] <= wr_tag;
			data_mem[s2_set] <= wr_data;
		end
	end

	assign hit_valid = do_hit;
	assign hit_rsp = '{core: s2_req.core, strand: s2_req.strand,
		op: s2_fill ? OP_LOAD : s2_req.op, address: s2_req.address, data: new_line};
	assign miss_valid = do_miss;
	assign miss_event = do_miss && !s2_fill;   // Core misses only
	assign miss_entry = '{req: s2_req, writeback: old_dirty,
		victim_addr: {s2_tag, s2_set}, victim_data: s2_data};
endmodule

`default_nettype wire

// File: source/l2_bus_interface.sv
`default_nettype none

module l2_bus_interface #(
	parameter int MISS_QUEUE_DEPTH = 4
) (
	input wire                                  clk,
	input wire                                  rst,
	input wire                                  miss_valid,
	input wire l2_cache_pkg::miss_entry_t       miss_entry,
	output logic                                queue_room,
	output logic                                restart_valid,
	output l2_cache_pkg::l2_req_t               restart_req,
	output l2_cache_pkg::line_data_t            restart_data,
	input wire                                  restart_taken,
	output logic [l2_axi_pkg::AXI_ADDR_BITS-1:0] axi_awaddr,
	output logic [7:0]                          axi_awlen,
	output logic                                axi_awvalid,
	input wire                                  axi_awready,
	output logic [l2_axi_pkg::AXI_DATA_BITS-1:0] axi_wdata,
	output logic                                axi_wlast,
	output logic                                axi_wvalid,
	input wire                                  axi_wready,
	input wire                                  axi_bvalid,
	output logic                                axi_bready,
	output logic [l2_axi_pkg::AXI_ADDR_BITS-1:0] axi_araddr,
	output logic [7:0]                          axi_arlen,
	output logic                                axi_arvalid,
	input wire                                  axi_arready,
	output logic                                axi_rready,
	input wire                                  axi_rvalid,
	input wire [l2_axi_pkg::AXI_DATA_BITS-1:0]  axi_rdata
);
	import l2_cache_pkg::*;
	import l2_axi_pkg::*;

	localparam int PTR_BITS = $clog2(MISS_QUEUE_DEPTH);
	localparam int BEAT_BITS = $clog2(LINE_WORDS);
	localparam int BYTE_SHIFT = $clog2(LINE_WORDS * 4);   // Line address to byte address

	miss_entry_t          queue [MISS_QUEUE_DEPTH];
	logic [PTR_BITS-1:0]  wr_ptr;
	logic [PTR_BITS-1:0]  rd_ptr;
	logic [PTR_BITS:0]    count;
	miss_entry_t          head;
	bus_state_t           state;
	logic [BEAT_BITS-1:0] beat;
	logic                 last_beat;
	line_data_t           line_buf;
	logic                 pop;

	assign head = queue[rd_ptr];
	assign pop = (state == BUS_RESTART) && restart_taken;   // Entry stays until replayed
	// Room for the new request plus two already in the pipeline
	assign queue_room = (MISS_QUEUE_DEPTH - int'(count)) >= 3;

	always_ff @(posedge clk) begin
		if (miss_valid)
			queue[wr_ptr] <= miss_entry;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (miss_valid)
				wr_ptr <= (wr_ptr == PTR_BITS'(MISS_QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_BITS'(MISS_QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			case ({miss_valid, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	assign last_beat = beat == BEAT_BITS'(LINE_WORDS - 1);

	// Beat counter wraps back to zero at the end of each burst
	always_ff @(posedge clk) begin
		if (rst) begin
			state <= BUS_IDLE;
			beat <= '0;
		end else begin
			case (state)
				BUS_IDLE:
					if (count != 0)
						state <= head.writeback ? BUS_WB_ADDR : BUS_RD_ADDR;
				BUS_WB_ADDR:
					if (axi_awready)
						state <= BUS_WB_DATA;
				BUS_WB_DATA:
					if (axi_wready) begin
						beat <= beat + 1'b1;
						if (last_beat)
							state <= BUS_WB_RESP;
					end
				BUS_WB_RESP:
					if (axi_bvalid)
						state <= BUS_RD_ADDR;
				BUS_RD_ADDR:
					if (axi_arready)
						state <= BUS_RD_DATA;
				BUS_RD_DATA:
					if (axi_rvalid) begin
						beat <= beat + 1'b1;
						if (last_beat)
							state <= BUS_RESTART;
					end
				BUS_RESTART:
					if (restart_taken)
						state <= BUS_IDLE;
				default: state <= BUS_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if ((state == BUS_RD_DATA) && axi_rvalid)
			line_buf[beat*AXI_DATA_BITS +: AXI_DATA_BITS] <= axi_rdata;   // Lowest word first
	end

	assign axi_awaddr = AXI_ADDR_BITS'(head.victim_addr) << BYTE_SHIFT;
	assign axi_awlen = BURST_LEN;
	assign axi_awvalid = state == BUS_WB_ADDR;
	assign axi_wdata = head.victim_data[beat*AXI_DATA_BITS +: AXI_DATA_BITS];
	assign axi_wvalid = state == BUS_WB_DATA;
	assign axi_wlast = axi_wvalid && last_beat;
	assign axi_bready = 1'b1;   // Response always accepted
	assign axi_araddr = AXI_ADDR_BITS'(head.req.address) << BYTE_SHIFT;
	assign axi_arlen = BURST_LEN;
	assign axi_arvalid = state == BUS_RD_ADDR;
	assign axi_rready = state == BUS_RD_DATA;

	assign restart_valid = state == BUS_RESTART;
	assign restart_req = head.req;
	assign restart_data = line_buf;
endmodule

`default_nettype wire

// File: source/l2_response.sv
`default_nettype none

module l2_response (
	input wire                        clk,
	input wire                        rst,
	input wire                        hit_valid,
	input wire l2_cache_pkg::l2_rsp_t hit_rsp,
	input wire                        miss_event,
	output logic                      rsp_valid,
	output l2_cache_pkg::l2_rsp_t     rsp,
	output logic                      pc_event_l2_hit,
	output logic                      pc_event_l2_miss
);
	// Core hits and replayed fills share the one response strobe
	always_ff @(posedge clk) begin
		if (rst) begin
			rsp_valid <= 1'b0;
			pc_event_l2_hit <= 1'b0;
			pc_event_l2_miss <= 1'b0;
		end else begin
			rsp_valid <= hit_valid;
			pc_event_l2_hit <= hit_valid;
			pc_event_l2_miss <= miss_event;   // Lines up with where the hit would be
		end
	end

	always_ff @(posedge clk) begin
		if (hit_valid)
			rsp <= hit_rsp;   // Held until the next response
	end
endmodule

`default_nettype wire

// File: source/l2_cache.sv
`default_nettype none

module l2_cache #(
	parameter int NUM_SETS = 16,
	parameter int MISS_QUEUE_DEPTH = 4
) (
	input wire                                     clk,
	input wire                                     rst,
	input wire                                     l2req_valid,
	input wire [1:0]                               l2req_core,
	input wire [1:0]                               l2req_strand,
	input wire l2_cache_pkg::l2_op_t               l2req_op,
	input wire [l2_cache_pkg::ADDR_BITS-1:0]       l2req_address,
	input wire [l2_cache_pkg::LINE_BITS-1:0]       l2req_data,
	input wire [l2_cache_pkg::MASK_BITS-1:0]       l2req_mask,
	output logic                                   l2req_ready,
	output logic                                   l2rsp_valid,
	output logic [1:0]                             l2rsp_core,
	output logic [1:0]                             l2rsp_strand,
	output l2_cache_pkg::l2_op_t                   l2rsp_op,
	output logic [l2_cache_pkg::ADDR_BITS-1:0]     l2rsp_address,
	output logic [l2_cache_pkg::LINE_BITS-1:0]     l2rsp_data,
	output logic [l2_axi_pkg::AXI_ADDR_BITS-1:0]   axi_awaddr,
	output logic [7:0]                             axi_awlen,
	output logic                                   axi_awvalid,
	input wire                                     axi_awready,
	output logic [l2_axi_pkg::AXI_DATA_BITS-1:0]   axi_wdata,
	output logic                                   axi_wlast,
	output logic                                   axi_wvalid,
	input wire                                     axi_wready,
	input wire                                     axi_bvalid,
	output logic                                   axi_bready,
	output logic [l2_axi_pkg::AXI_ADDR_BITS-1:0]   axi_araddr,
	output logic [7:0]                             axi_arlen,
	output logic                                   axi_arvalid,
	input wire                                     axi_arready,
	output logic                                   axi_rready,
	input wire                                     axi_rvalid,
	input wire [l2_axi_pkg::AXI_DATA_BITS-1:0]     axi_rdata,
	output logic                                   pc_event_l2_hit,
	output logic                                   pc_event_l2_miss,
	output logic                                   pc_event_l2_wait
);
	import l2_cache_pkg::*;

	l2_req_t     core_req;
	l2_rsp_t     rsp;
	logic        arb_valid;
	l2_req_t     arb_req;
	logic        arb_is_fill;
	line_data_t  arb_fill_data;
	logic        restart_valid;
	l2_req_t     restart_req;
	line_data_t  restart_data;
	logic        restart_taken;
	logic        queue_room;
	logic        hit_valid;
	l2_rsp_t     hit_rsp;
	logic        miss_event;
	logic        miss_valid;
	miss_entry_t miss_entry;

	assign core_req = '{core: l2req_core, strand: l2req_strand, op: l2req_op,
		address: l2req_address, data: l2req_data, mask: l2req_mask};

	assign l2rsp_core = rsp.core;
	assign l2rsp_strand = rsp.strand;
	assign l2rsp_op = rsp.op;
	assign l2rsp_address = rsp.address;
	assign l2rsp_data = rsp.data;

	l2_request_arb u_arb (
		.clk(clk), .rst(rst),
		.core_valid(l2req_valid), .core_req(core_req),
		.l2req_ready(l2req_ready), .pc_event_l2_wait(pc_event_l2_wait),
		.restart_valid(restart_valid), .restart_req(restart_req),
		.restart_data(restart_data), .queue_room(queue_room),
		.restart_taken(restart_taken),
		.arb_valid(arb_valid), .arb_req(arb_req),
		.arb_is_fill(arb_is_fill), .arb_fill_data(arb_fill_data));

	l2_cache_lookup #(.NUM_SETS(NUM_SETS)) u_lookup (
		.clk(clk), .rst(rst),
		.arb_valid(arb_valid), .arb_req(arb_req),
		.arb_is_fill(arb_is_fill), .arb_fill_data(arb_fill_data),
		.hit_valid(hit_valid), .hit_rsp(hit_rsp), .miss_event(miss_event),
		.miss_valid(miss_valid), .miss_entry(miss_entry));

	l2_bus_interface #(.MISS_QUEUE_DEPTH(MISS_QUEUE_DEPTH)) u_bus (
		.clk(clk), .rst(rst),
		.miss_valid(miss_valid), .miss_entry(miss_entry),
		.queue_room(queue_room), .restart_valid(restart_valid),
		.restart_req(restart_req), .restart_data(restart_data),
		.restart_taken(restart_taken),
		.axi_awaddr(axi_awaddr), .axi_awlen(axi_awlen),
		.axi_awvalid(axi_awvalid), .axi_awready(axi_awready),
		.axi_wdata(axi_wdata), .axi_wlast(axi_wlast),
		.axi_wvalid(axi_wvalid), .axi_wready(axi_wready),
		.axi_bvalid(axi_bvalid), .axi_bready(axi_bready),
		.axi_araddr(axi_araddr), .axi_arlen(axi_arlen),
		.axi_arvalid(axi_arvalid), .axi_arready(axi_arready),
		.axi_rready(axi_rready), .axi_rvalid(axi_rvalid), .axi_rdata(axi_rdata));

	l2_response u_response (
		.clk(clk), .rst(rst),
		.hit_valid(hit_valid), .hit_rsp(hit_rsp), .miss_event(miss_event),
		.rsp_valid(l2rsp_valid), .rsp(rsp),
		.pc_event_l2_hit(pc_event_l2_hit), .pc_event_l2_miss(pc_event_l2_miss));
endmodule

`default_nettype wire

// File: testbench/l2_cache_tb.sv
`default_nettype none

module l2_cache_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import l2_cache_pkg::*;

	localparam int NUM_SETS = 16;
	localparam int MISS_QUEUE_DEPTH = 4;
	localparam int RAND_REQS = 40;
	localparam int MAX_CYCLES = 4000;   // 40 requests at about 60 cycles each, plus margin
	localparam int LINES = 64;          // Stimulus stays inside these line addresses

	logic         clk = 1'b0;
	logic         rst = 1'b1;
	logic         l2req_valid = 1'b0;
	logic [1:0]   l2req_core = '0;
	logic [1:0]   l2req_strand = '0;
	l2_op_t       l2req_op = OP_LOAD;
	line_addr_t   l2req_address = '0;
	line_data_t   l2req_data = '0;
	line_mask_t   l2req_mask = '0;
	logic         l2req_ready;
	logic         l2rsp_valid;
	logic [1:0]   l2rsp_core;
	logic [1:0]   l2rsp_strand;
	l2_op_t       l2rsp_op;
	line_addr_t   l2rsp_address;
	line_data_t   l2rsp_data;
	logic [31:0]  axi_awaddr;
	logic [7:0]   axi_awlen;
	logic         axi_awvalid;
	logic         axi_awready = 1'b0;
	logic [31:0]  axi_wdata;
	logic         axi_wlast;
	logic         axi_wvalid;
	logic         axi_wready = 1'b0;
	logic         axi_bvalid = 1'b0;
	logic         axi_bready;
	logic [31:0]  axi_araddr;
	logic [7:0]   axi_arlen;
	logic         axi_arvalid;
	logic         axi_arready = 1'b0;
	logic         axi_rready;
	logic         axi_rvalid = 1'b0;
	logic [31:0]  axi_rdata = '0;
	logic         pc_event_l2_hit;
	logic         pc_event_l2_miss;
	logic         pc_event_l2_wait;

	integer       seed = 32'ha98e;
	int           cycles = 0;
	int           accepted = 0;
	int           responses = 0;
	line_data_t   mem [LINES];        // Backing store, writebacks land here
	logic [5:0]   wr_line;
	logic [1:0]   wr_beat;
	logic         resp_due;
	logic [5:0]   rd_line;
	logic [1:0]   rd_beat;
	logic [2:0]   rd_left;            // Read beats still owed
	logic [5:0]   rand_addr [RAND_REQS];
	logic [3:0]   rand_id [RAND_REQS];

	l2_cache #(.NUM_SETS(NUM_SETS), .MISS_QUEUE_DEPTH(MISS_QUEUE_DEPTH)) uut (.*);

	initial begin
		forever #4 clk = ~clk;
	end

	initial begin
		for (int a = 0; a < LINES; a++)
			for (int i = 0; i < LINE_WORDS; i++)
				mem[a][i*32 +: 32] = a * LINE_WORDS + i;   // Word i of line a
	end

	// Memory model, handshakes seen at the rising edge
	always @(posedge clk) begin
		if (rst) begin
			resp_due <= 1'b0;
			wr_beat <= '0;
			rd_beat <= '0;
			rd_left <= '0;
		end else begin
			if (axi_awvalid && axi_awready)
				wr_line <= 6'(axi_awaddr >> 4);
			if (axi_wvalid && axi_wready) begin
				mem[wr_line][wr_beat*32 +: 32] <= axi_wdata;
				wr_beat <= wr_beat + 1'b1;
				if (axi_wlast)
					resp_due <= 1'b1;   // B response owed after last beat
			end
			if (axi_bvalid && axi_bready)
				resp_due <= 1'b0;
			if (axi_arvalid && axi_arready) begin
				rd_line <= 6'(axi_araddr >> 4);
				rd_left <= 3'(LINE_WORDS);
			end
			if (axi_rvalid && axi_rready) begin
				rd_beat <= rd_beat + 1'b1;
				rd_left <= rd_left - 1'b1;
			end
		end
	end

	// Random ready and valid delays, driven on the falling edge
	always @(negedge clk) begin
		if (rst) begin
			axi_awready <= 1'b0;
			axi_wready <= 1'b0;
			axi_bvalid <= 1'b0;
			axi_arready <= 1'b0;
			axi_rvalid <= 1'b0;
		end else begin
			axi_awready <= ($random(seed) & 3) != 0;
			axi_wready <= ($random(seed) & 3) != 0;
			axi_bvalid <= resp_due && (($random(seed) & 3) != 0);
			axi_arready <= ($random(seed) & 3) != 0;
			axi_rvalid <= (rd_left != 0) && (($random(seed) & 3) != 0);
			axi_rdata <= mem[rd_line][rd_beat*32 +: 32];
		end
	end

	always @(posedge clk) begin
		if (l2rsp_valid)
			responses <= responses + 1;
	end

	always @(negedge clk) begin
		cycles <= cycles + 1;
		if (uut.u_chk.error_count != 0) begin
			$display("Something failed");
			$fatal(1, "A checker assertion failed");
		end else if (cycles >= MAX_CYCLES) begin
			$display("Something failed");
			$fatal(1, "Timeout, the requests did not all complete in %0d cycles", MAX_CYCLES);
		end
	end

	// Called on a falling edge, returns on the falling edge after acceptance
	task automatic issue(input l2_op_t op, input logic [3:0] id, input line_addr_t addr,
		input line_data_t data, input line_mask_t mask);
		logic ready_now;
		l2req_valid = 1'b1;
		l2req_op = op;
		l2req_core = id[3:2];
		l2req_strand = id[1:0];
		l2req_address = addr;
		l2req_data = data;
		l2req_mask = mask;
		ready_now = l2req_ready;   // Only depends on registers, stable until the edge
		@(negedge clk);
		while (!ready_now) begin
			ready_now = l2req_ready;
			@(negedge clk);
		end
		accepted++;
	endtask

	task automatic drain();
		l2req_valid = 1'b0;
		while (responses != accepted)
			@(negedge clk);
		repeat (2) @(negedge clk);
	endtask

	initial begin
		for (int n = 0; n < RAND_REQS; n++) begin
			rand_addr[n] = 6'($random(seed));
			rand_id[n] = 4'($random(seed));
		end
		repeat (4) @(negedge clk);
		rst = 1'b0;
		repeat (5) @(negedge clk);   // Quiet stretch after reset
		issue(OP_LOAD, 4'h1, 26'd5, '0, '0);   // Cold miss
		drain();
		issue(OP_LOAD, 4'h2, 26'd5, '0, '0);   // Hit on the filled line
		drain();
		issue(OP_STORE, 4'h3, 26'd5,
			{32'hdead_beef, 32'h0bad_f00d, 32'h1234_5678, 32'h9abc_def0}, 16'h0f35);
		drain();
		issue(OP_LOAD, 4'h4, 26'd5, '0, '0);
		drain();
		issue(OP_LOAD, 4'h5, 26'(5 + NUM_SETS), '0, '0);   // Evicts the dirty line
		drain();
		for (int n = 0; n < RAND_REQS; n++)
			issue(OP_LOAD, rand_id[n], line_addr_t'(rand_addr[n]), '0, '0);
		drain();
		if (uut.u_chk.error_count == 0) begin
			$display("Everything OK");
			$finish;
		end else begin
			$display("Something failed");
			$fatal(1, "Checker assertions failed");
		end
	end
endmodule

`default_nettype wire

// File: testbench/l2_cache_chk.sv
`default_nettype none

module l2_cache_chk (
	input wire                                   clk,
	input wire                                   rst,
	input wire                                   l2req_valid,
	input wire                                   l2req_ready,
	input wire [1:0]                             l2req_core,
	input wire [1:0]                             l2req_strand,
	input wire l2_cache_pkg::l2_op_t             l2req_op,
	input wire [l2_cache_pkg::ADDR_BITS-1:0]     l2req_address,
	input wire [l2_cache_pkg::LINE_BITS-1:0]     l2req_data,
	input wire [l2_cache_pkg::MASK_BITS-1:0]     l2req_mask,
	input wire                                   l2rsp_valid,
	input wire [1:0]                             l2rsp_core,
	input wire [1:0]                             l2rsp_strand,
	input wire l2_cache_pkg::l2_op_t             l2rsp_op,
	input wire [l2_cache_pkg::ADDR_BITS-1:0]     l2rsp_address,
	input wire [l2_cache_pkg::LINE_BITS-1:0]     l2rsp_data,
	input wire [l2_axi_pkg::AXI_ADDR_BITS-1:0]   axi_awaddr,
	input wire [7:0]                             axi_awlen,
	input wire                                   axi_awvalid,
	input wire                                   axi_awready,
	input wire [l2_axi_pkg::AXI_DATA_BITS-1:0]   axi_wdata,
	input wire                                   axi_wlast,
	input wire                                   axi_wvalid,
	input wire                                   axi_wready,
	input wire                                   axi_bready,
	input wire [l2_axi_pkg::AXI_ADDR_BITS-1:0]   axi_araddr,
	input wire [7:0]                             axi_arlen,
	input wire                                   axi_arvalid,
	input wire                                   axi_arready,
	input wire                                   axi_rready,
	input wire                                   pc_event_l2_hit,
	input wire                                   pc_event_l2_miss,
	input wire                                   pc_event_l2_wait
);
	timeunit 1ns;
	timeprecision 100ps;
	import l2_cache_pkg::*;
	import l2_axi_pkg::*;

	localparam int SLOTS = 16;      // Outstanding requests tracked
	localparam int LINES = 64;
	localparam int BYTE_SHIFT = $clog2(LINE_WORDS * 4);

	int               error_count;
	line_data_t       shadow [LINES];   // Expected line contents
	l2_req_t          slot_req [SLOTS];
	logic [SLOTS-1:0] slot_used;
	logic             seen_req;
	logic [5:0]       wb_line;
	logic [1:0]       wb_beat;
	int               free_slot;
	int               rsp_slot;
	logic             rsp_found;
	l2_req_t          rsp_req;
	line_data_t       rsp_expect;
	logic             ar_known;         // Read burst belongs to an open request
	logic [31:0]      wb_expect;
	logic             accept;
	line_addr_t       last_rsp_addr;    // Line of the latest response
	logic             last_rsp_ok;

	function automatic line_data_t merge_store(line_data_t base, l2_req_t req);
		line_data_t line;
		line = base;
		for (int i = 0; i < MASK_BITS; i++)
			if (req.mask[i])
				line[i*8 +: 8] = req.data[i*8 +: 8];
		return line;
	endfunction

	initial begin
		error_count = 0;
		for (int a = 0; a < LINES; a++)
			for (int i = 0; i < LINE_WORDS; i++)
				shadow[a][i*32 +: 32] = a * LINE_WORDS + i;   // Memory pattern
	end

	assign accept = l2req_valid && l2req_ready;

	always_comb begin
		free_slot = 0;
		rsp_slot = -1;
		rsp_found = 1'b0;
		rsp_req = '0;
		ar_known = 1'b0;
		for (int s = SLOTS - 1; s >= 0; s--)
			if (!slot_used[s])
				free_slot = s;
		for (int s = 0; s < SLOTS; s++) begin
			if (slot_used[s] && !rsp_found && slot_req[s].core == l2rsp_core &&
				slot_req[s].strand == l2rsp_strand && slot_req[s].address == l2rsp_address) begin
				rsp_found = 1'b1;
				rsp_slot = s;
				rsp_req = slot_req[s];
			end
			if (slot_used[s] && 32'(slot_req[s].address) == (axi_araddr >> BYTE_SHIFT))
				ar_known = 1'b1;
		end
		rsp_expect = shadow[l2rsp_address[5:0]];
		if (rsp_found && rsp_req.op == OP_STORE)
			rsp_expect = merge_store(rsp_expect, rsp_req);   // Store bytes over the old line
		wb_expect = shadow[wb_line][32*wb_beat +: 32];
	end

	always @(posedge clk) begin
		if (rst) begin
			slot_used <= '0;
			seen_req <= 1'b0;
			wb_beat <= '0;
			last_rsp_ok <= 1'b0;
		end else begin
			if (l2req_valid)
				seen_req <= 1'b1;
			if (l2rsp_valid) begin
				last_rsp_ok <= 1'b1;
				last_rsp_addr <= l2rsp_address;
			end
			if (l2rsp_valid && rsp_found) begin
				slot_used[rsp_slot] <= 1'b0;
				shadow[l2rsp_address[5:0]] <= rsp_expect;
			end
			if (accept) begin
				slot_used[free_slot] <= 1'b1;
				slot_req[free_slot] <= '{core: l2req_core, strand: l2req_strand, op: l2req_op,
					address: l2req_address, data: l2req_data, mask: l2req_mask};
			end
			if (axi_awvalid && axi_awready)
				wb_line <= 6'(axi_awaddr >> BYTE_SHIFT);
			if (axi_wvalid && axi_wready)
				wb_beat <= wb_beat + 1'b1;
		end
	end

	a_quiet: assert property (@(posedge clk) disable iff (rst)
		!seen_req |-> !(l2rsp_valid || axi_arvalid || axi_awvalid || axi_rready ||
		pc_event_l2_hit || pc_event_l2_miss || pc_event_l2_wait))
	else begin
		error_count++;
		$error("ERR %0t: activity before the first request", $time);
	end

	// Every accepted request either hits 3 cycles later or reports a miss there
	a_latency: assert property (@(posedge clk) disable iff (rst)
		accept |-> ##3 (pc_event_l2_miss !=
		(l2rsp_valid && pc_event_l2_hit && l2rsp_address == $past(l2req_address, 3) &&
		l2rsp_op == $past(l2req_op, 3))))
	else begin
		error_count++;
		$error("ERR %0t: no hit response or miss event 3 cycles after acceptance", $time);
	end

	// Nothing in flight and the line was just answered, so it is still resident
	a_hit: assert property (@(posedge clk) disable iff (rst)
		(accept && slot_used == '0 && last_rsp_ok && l2req_address == last_rsp_addr) |->
		##3 (pc_event_l2_hit && !pc_event_l2_miss))
	else begin
		error_count++;
		$error("ERR %0t: repeat access to a resident line did not hit", $time);
	end

	// Replayed fills answer with OP_LOAD
	a_response: assert property (@(posedge clk) disable iff (rst)
		l2rsp_valid |-> rsp_found && l2rsp_data == rsp_expect &&
		(l2rsp_op == OP_LOAD || rsp_req.op == OP_STORE))
	else begin
		error_count++;
		$error("ERR %0t: response for line %0h unmatched or with wrong data", $time,
			l2rsp_address);
	end

	a_read_burst: assert property (@(posedge clk) disable iff (rst)
		(axi_arvalid && axi_arready) |->
		axi_arlen == BURST_LEN && axi_araddr[BYTE_SHIFT-1:0] == '0 && ar_known)
	else begin
		error_count++;
		$error("ERR %0t: bad read burst at %0h", $time, axi_araddr);
	end

	a_write_addr: assert property (@(posedge clk) disable iff (rst)
		(axi_awvalid && axi_awready) |->
		axi_awlen == BURST_LEN && axi_awaddr[BYTE_SHIFT-1:0] == '0)
	else begin
		error_count++;
		$error("ERR %0t: bad write burst at %0h", $time, axi_awaddr);
	end

	a_write_data: assert property (@(posedge clk) disable iff (rst)
		(axi_wvalid && axi_wready) |->
		axi_wlast == (wb_beat == 2'(LINE_WORDS - 1)) && axi_wdata == wb_expect)
	else begin
		error_count++;
		$error("ERR %0t: writeback beat %0d wrong data or wlast", $time, wb_beat);
	end

	// Read data only accepted once no address or write phase is open
	a_ready: assert property (@(posedge clk) disable iff (rst)
		axi_bready && !(axi_rready && (axi_arvalid || axi_awvalid || axi_wvalid)))
	else begin
		error_count++;
		$error("ERR %0t: bready low or rready outside a read burst", $time);
	end

	a_wait_event: assert property (@(posedge clk) disable iff (rst)
		pc_event_l2_wait == (l2req_valid && !l2req_ready))
	else begin
		error_count++;
		$error("ERR %0t: wait event does not match a held-off request", $time);
	end
endmodule

bind l2_cache l2_cache_chk u_chk (.*);

`default_nettype wire

// File: verilog.f
source/l2_cache_pkg.sv
source/l2_axi_pkg.sv
source/l2_request_arb.sv
source/l2_cache_lookup.sv
source/l2_bus_interface.sv
source/l2_response.sv
source/l2_cache.sv
testbench/l2_cache_tb.sv
testbench/l2_cache_chk.sv
